/* Makefile */
# Verilator build and run of the branch unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_branch_unit
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Test passed

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.DEFAULT_GOAL := test
.PHONY: test clean help

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# fails unless the simulation prints the pass message.
test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

/* branch_cmp.sv */
// branch comparator with equality and signed or unsigned less-than of the execute operands.
`timescale 1ns/1ns

module branch_cmp
#(
	parameter int XLEN = branch_pkg::xlen
)
(
	input  logic [XLEN-1:0]        rs1_data,
	input  logic [XLEN-1:0]        rs2_data,
	input  branch_pkg::branch_fn_t funct3,
	output logic                   br_eq,
	output logic                   br_lt
);

	logic cmp_unsigned;
	logic lt_signed;
	logic lt_unsigned;

	// bltu and bgeu compare as unsigned.
	assign cmp_unsigned = (funct3 == branch_pkg::fn_bltu) ||
		(funct3 == branch_pkg::fn_bgeu);

	assign lt_signed = $signed(rs1_data) < $signed(rs2_data);
	assign lt_unsigned = rs1_data < rs2_data;

	assign br_eq = (rs1_data == rs2_data);

	// one less-than flag, the mode follows funct3.
	always_comb
	begin
		if (cmp_unsigned)
			br_lt = lt_unsigned;
		else
			br_lt = lt_signed;
	end

endmodule

/* branch_pkg.sv */
// shared data width, rv32i opcode and branch condition enums, next-pc select and field helpers.
package branch_pkg;

	// data and address width of the core.
	localparam int xlen = 32;

	// rv32i major opcodes seen by the control-flow slice.
	typedef enum logic [6:0]
	{
		op_load   = 7'b0000011,
		op_op_imm = 7'b0010011,
		op_auipc  = 7'b0010111,
		op_store  = 7'b0100011,
		op_op     = 7'b0110011,
		op_lui    = 7'b0110111,
		op_branch = 7'b1100011, // conditional branches.
		op_jalr   = 7'b1100111, // register-relative jump.
		op_jal    = 7'b1101111  // pc-relative jump.
	} opcode_t;

	// funct3 encodings of the conditional branches.
	// 3'b010 and 3'b011 are not branches.
	typedef enum logic [2:0]
	{
		fn_beq  = 3'b000,
		fn_bne  = 3'b001,
		fn_blt  = 3'b100,
		fn_bge  = 3'b101,
		fn_bltu = 3'b110,
		fn_bgeu = 3'b111
	} branch_fn_t;

	// next-pc source.
	typedef enum logic
	{
		pc_seq    = 1'b0, // pc plus 4.
		pc_target = 1'b1  // computed branch or jump target.
	} pc_src_t;

	// major opcode field of an instruction word.
	function automatic opcode_t inst_opcode
	(
		input logic [31:0] inst
	);
		return opcode_t'(inst[6:0]);
	endfunction

	// funct3 field of an instruction word.
	// the cast keeps non-branch encodings, callers treat them as no match.
	function automatic branch_fn_t inst_funct3
	(
		input logic [31:0] inst
	);
		return branch_fn_t'(inst[14:12]);
	endfunction

endpackage

/* branch_unit.sv */
// branch unit top level with fetch pc, comparator, target adder and next-pc select.
`timescale 1ns/1ns

module branch_unit
#(
	parameter int              XLEN     = branch_pkg::xlen,
	parameter logic [XLEN-1:0] RESET_PC = '0
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic [31:0]     inst,
	input  logic            inst_valid,
	input  logic [XLEN-1:0] rs1_data,
	input  logic [XLEN-1:0] rs2_data,
	output logic [XLEN-1:0] pc,
	output logic            redirect,
	output logic [XLEN-1:0] redirect_target,
	output logic            link_valid,
	output logic [XLEN-1:0] link_data
);

	// execute stage.
	logic [31:0]         ex_inst;
	logic [XLEN-1:0]     ex_pc;
	logic                ex_valid;

	// comparator flags.
	logic                br_eq;
	logic                br_lt;

	branch_pkg::pc_src_t pc_src;

	fetch_pc
	#(
		.XLEN     (XLEN),
		.RESET_PC (RESET_PC)
	)
	u_fetch_pc
	(
		.clk        (clk),
		.rst        (rst),
		.inst       (inst),
		.inst_valid (inst_valid),
		.redirect   (redirect),
		.target     (redirect_target),
		.pc         (pc),
		.ex_inst    (ex_inst),
		.ex_pc      (ex_pc),
		.ex_valid   (ex_valid)
	);

	branch_cmp
	#(
		.XLEN (XLEN)
	)
	u_branch_cmp
	(
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.funct3   (branch_pkg::inst_funct3(ex_inst)),
		.br_eq    (br_eq),
		.br_lt    (br_lt)
	);

	imm_target
	#(
		.XLEN (XLEN)
	)
	u_imm_target
	(
		.ex_inst   (ex_inst),
		.ex_pc     (ex_pc),
		.rs1_data  (rs1_data),
		.target    (redirect_target),
		.link_data (link_data)
	);

	pc_sel u_pc_sel
	(
		.ex_inst    (ex_inst),
		.ex_valid   (ex_valid),
		.br_eq      (br_eq),
		.br_lt      (br_lt),
		.pc_src     (pc_src),
		.redirect   (redirect),
		.link_valid (link_valid)
	);

endmodule

/* build.f */
branch_pkg.sv
branch_cmp.sv
imm_target.sv
pc_sel.sv
fetch_pc.sv
branch_unit.sv
tb_branch_unit.sv

/* fetch_pc.sv */
// program counter register and fetch-to-execute pipeline register with stall and squash.
`timescale 1ns/1ns

module fetch_pc
#(
	parameter int              XLEN     = branch_pkg::xlen,
	parameter logic [XLEN-1:0] RESET_PC = '0
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic [31:0]     inst,
	input  logic            inst_valid,
	input  logic            redirect,
	input  logic [XLEN-1:0] target,
	output logic [XLEN-1:0] pc,
	output logic [31:0]     ex_inst,
	output logic [XLEN-1:0] ex_pc,
	output logic            ex_valid
);

	logic            accept;
	logic [XLEN-1:0] pc_next;

	// the word fetched behind a taken redirect is dropped.
	assign accept = inst_valid && !redirect;

	// next fetch address.
	always_comb
	begin
		if (redirect)
			pc_next = target; // moves even while fetch is stalled.
		else if (inst_valid)
			pc_next = pc + XLEN'(4);
		else
			pc_next = pc; // stall.
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	// execute slot is a bubble on a stall or a squash.
	always_ff @(posedge clk)
	begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= accept;
	end

	// instruction and its address move to execute together.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			ex_inst <= inst;
			ex_pc <= pc;
		end
	end

endmodule

/* imm_target.sv */
// immediate decode, redirect target adder and link value for the execute-stage instruction.
`timescale 1ns/1ns

module imm_target
#(
	parameter int XLEN = branch_pkg::xlen
)
(
	input  logic [31:0]     ex_inst,
	input  logic [XLEN-1:0] ex_pc,
	input  logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] target,
	output logic [XLEN-1:0] link_data
);

	branch_pkg::opcode_t opcode;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] base;
	logic [XLEN-1:0] offset;
	logic [XLEN-1:0] sum;
	logic            is_jalr;

	assign opcode = branch_pkg::inst_opcode(ex_inst);
	assign is_jalr = (opcode == branch_pkg::op_jalr);

	// b-type, bit 0 is always zero.
	assign imm_b = {{(XLEN-12){ex_inst[31]}}, ex_inst[7], ex_inst[30:25],
		ex_inst[11:8], 1'b0};

	// j-type, scattered 20-bit offset.
	assign imm_j = {{(XLEN-20){ex_inst[31]}}, ex_inst[19:12], ex_inst[20],
		ex_inst[30:21], 1'b0};

	// i-type for jalr.
	assign imm_i = {{(XLEN-11){ex_inst[31]}}, ex_inst[30:20]};

	// base and offset by opcode.
	always_comb
	begin
		case (opcode)
			branch_pkg::op_jal:
			begin
				base = ex_pc;
				offset = imm_j;
			end
			branch_pkg::op_jalr:
			begin
				base = rs1_data; // register relative.
				offset = imm_i;
			end
			default:
			begin
				// branch form; the target is ignored for other opcodes.
				base = ex_pc;
				offset = imm_b;
			end
		endcase
	end

	assign sum = base + offset;

	// jalr drops bit 0 of the sum.
	always_comb
	begin
		if (is_jalr)
			target = {sum[XLEN-1:1], 1'b0};
		else
			target = sum;
	end

	assign link_data = ex_pc + XLEN'(4); // return address.

endmodule

/* pc_sel.sv */
// next-pc select with redirect and link strobes from the execute opcode, funct3 and flags.
`timescale 1ns/1ns

module pc_sel
(
	input  logic [31:0]         ex_inst,
	input  logic                ex_valid,
	input  logic                br_eq,
	input  logic                br_lt,
	output branch_pkg::pc_src_t pc_src,
	output logic                redirect,
	output logic                link_valid
);

	branch_pkg::opcode_t    opcode;
	branch_pkg::branch_fn_t funct3;
	logic                   is_branch;
	logic                   is_jump;
	logic                   cond_true;

	assign opcode = branch_pkg::inst_opcode(ex_inst);
	assign funct3 = branch_pkg::inst_funct3(ex_inst);

	assign is_branch = (opcode == branch_pkg::op_branch);
	assign is_jump = (opcode == branch_pkg::op_jal) || (opcode == branch_pkg::op_jalr);

	// branch condition from the comparator flags.
	always_comb
	begin
		case (funct3)
			branch_pkg::fn_beq:
				cond_true = br_eq;
			branch_pkg::fn_bne:
				cond_true = !br_eq;
			branch_pkg::fn_blt, branch_pkg::fn_bltu:
				cond_true = br_lt; // signedness already chosen by the comparator.
			branch_pkg::fn_bge, branch_pkg::fn_bgeu:
				cond_true = !br_lt;
			default:
				cond_true = 1'b0; // 010 and 011 never branch.
		endcase
	end

	// jumps always take the target, a bubble never does.
	always_comb
	begin
		if (ex_valid && (is_jump || (is_branch && cond_true)))
			pc_src = branch_pkg::pc_target;
		else
			pc_src = branch_pkg::pc_seq;
	end

	assign redirect = (pc_src == branch_pkg::pc_target);
	assign link_valid = ex_valid && is_jump; // jal and jalr write the return address.

endmodule

/* tb_branch_unit.sv */
// testbench for the branch unit with random program memory, reference model, checks and timeout.
`timescale 1ns/1ns

module tb_branch_unit;

	localparam int          xlen        = branch_pkg::xlen;
	localparam logic [31:0] reset_pc    = 32'h0000_0100;
	localparam int          seed        = 38;
	localparam int          n_inst      = 2000;
	localparam int          n_drain     = 4; // idle cycles so the last fetch reaches execute.
	localparam int          cycle_limit = n_inst + 200;
	localparam int          mem_words   = 1024;

	logic            clk;
	logic            rst;
	logic [31:0]     inst;
	logic            inst_valid;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] pc;
	logic            redirect;
	logic [xlen-1:0] redirect_target;
	logic            link_valid;
	logic [xlen-1:0] link_data;

	logic [31:0] prog_mem [mem_words]; // word addressed by pc[11:2].

	// reference model state.
	logic [xlen-1:0] m_pc;
	logic            m_ex_valid;
	logic [31:0]     m_ex_inst;
	logic [xlen-1:0] m_ex_pc;

	// expected outputs of the current cycle.
	logic            exp_redirect;
	logic [xlen-1:0] exp_target;
	logic            exp_link;
	logic [xlen-1:0] exp_link_data;
	string           test_name;

	int errors;
	int checks;
	int n_redirect;
	int n_link;
	int n_stall;
	int idx;
	int rnd;
	int cycle_count = 0;

	branch_unit
	#(
		.XLEN     (xlen),
		.RESET_PC (reset_pc)
	)
	u_branch_unit
	(
		.clk             (clk),
		.rst             (rst),
		.inst            (inst),
		.inst_valid      (inst_valid),
		.rs1_data        (rs1_data),
		.rs2_data        (rs2_data),
		.pc              (pc),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.link_valid      (link_valid),
		.link_data       (link_data)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk; // 40 ns period.

	// random word with a weighted mix of branches, jumps and sequential opcodes.
	function automatic logic [31:0] random_inst();
		logic [31:0] w;
		int kind;
		w = $urandom;
		kind = $urandom_range(0, 15);
		if (kind < 6)
		begin
			w[6:0] = branch_pkg::op_branch;
			case ($urandom_range(0, 6))
				0: w[14:12] = branch_pkg::fn_beq;
				1: w[14:12] = branch_pkg::fn_bne;
				2: w[14:12] = branch_pkg::fn_blt;
				3: w[14:12] = branch_pkg::fn_bge;
				4: w[14:12] = branch_pkg::fn_bltu;
				5: w[14:12] = branch_pkg::fn_bgeu;
				default: w[14:12] = {2'b01, w[12]}; // 010 or 011, no branch condition.
			endcase
		end
		else if (kind < 8)
			w[6:0] = branch_pkg::op_jal;
		else if (kind < 10)
		begin
			w[6:0] = branch_pkg::op_jalr;
			w[14:12] = 3'b000;
		end
		else
		begin
			case ($urandom_range(0, 5))
				0: w[6:0] = branch_pkg::op_lui;
				1: w[6:0] = branch_pkg::op_auipc;
				2: w[6:0] = branch_pkg::op_op;
				3: w[6:0] = branch_pkg::op_op_imm;
				4: w[6:0] = branch_pkg::op_load;
				default: w[6:0] = branch_pkg::op_store;
			endcase
		end
		return w;
	endfunction

	// small pool with equal, sign-differing and boundary values.
	function automatic logic [31:0] pick_operand();
		case ($urandom_range(0, 7))
			0: return 32'h0000_0000;
			1: return 32'h0000_0001;
			2: return 32'hffff_ffff; // negative signed, largest unsigned.
			3: return 32'h7fff_ffff;
			4: return 32'h8000_0000;
			5: return 32'h0000_0005;
			6: return 32'hffff_fffb;
			default: return $urandom;
		endcase
	endfunction

	// rv32i branch condition by funct3.
	function automatic logic model_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// target of a jal, jalr or branch at ex_pc.
	function automatic logic [31:0] model_target(logic [31:0] w, logic [31:0] at, logic [31:0] rs1);
		logic [31:0] imm;
		if (w[6:0] == 7'b1101111)
		begin
			imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			return at + imm;
		end
		else if (w[6:0] == 7'b1100111)
		begin
			imm = {{20{w[31]}}, w[31:20]};
			return (rs1 + imm) & 32'hffff_fffe;
		end
		imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		return at + imm;
	endfunction

	// inputs for one cycle, read from memory at the dut pc.
	task automatic drive_cycle(input logic fetch_on);
		inst_valid = fetch_on && ($urandom_range(0, 4) != 0); // stall about one in five.
		inst = prog_mem[pc[11:2]];
		rs1_data = pick_operand();
		rs2_data = pick_operand();
		if (!inst_valid)
			n_stall++;
	endtask

	task automatic predict_outputs();
		exp_redirect = 1'b0;
		exp_link = 1'b0;
		exp_target = model_target(m_ex_inst, m_ex_pc, rs1_data);
		exp_link_data = m_ex_pc + 32'd4;
		if (!m_ex_valid)
			test_name = "bubble";
		else if (m_ex_inst[6:0] == 7'b1100011)
		begin
			test_name = "branch";
			exp_redirect = model_taken(m_ex_inst[14:12], rs1_data, rs2_data);
		end
		else if (m_ex_inst[6:0] == 7'b1101111 || m_ex_inst[6:0] == 7'b1100111)
		begin
			test_name = (m_ex_inst[6:0] == 7'b1101111) ? "jal" : "jalr";
			exp_redirect = 1'b1;
			exp_link = 1'b1;
		end
		else
			test_name = "sequential";
	endtask

	task automatic check_outputs();
		checks++;
		if (pc !== m_pc)
		begin
			errors++;
			$display("ERR %s pc cycle %0d exp %h act %h", test_name, cycle_count, m_pc, pc);
		end
		if (redirect !== exp_redirect)
		begin
			errors++;
			$display("ERR %s redirect cycle %0d exp %b act %b", test_name, cycle_count,
				exp_redirect, redirect);
		end
		if (exp_redirect && redirect_target !== exp_target)
		begin
			errors++;
			$display("ERR %s redirect_target cycle %0d exp %h act %h", test_name, cycle_count,
				exp_target, redirect_target);
		end
		if (link_valid !== exp_link)
		begin
			errors++;
			$display("ERR %s link_valid cycle %0d exp %b act %b", test_name, cycle_count,
				exp_link, link_valid);
		end
		if (exp_link && link_data !== exp_link_data)
		begin
			errors++;
			$display("ERR %s link_data cycle %0d exp %h act %h", test_name, cycle_count,
				exp_link_data, link_data);
		end
	endtask

	// state the dut should hold after the coming rising edge.
	task automatic advance_model();
		logic accept;
		accept = inst_valid && !exp_redirect; // fetch behind a redirect is squashed.
		if (accept)
		begin
			m_ex_inst = inst;
			m_ex_pc = m_pc;
		end
		m_ex_valid = accept;
		if (exp_redirect)
		begin
			n_redirect++;
			m_pc = exp_target;
		end
		else if (inst_valid)
			m_pc = m_pc + 32'd4;
		if (exp_link)
			n_link++;
	endtask

	initial
	begin
		rnd = $urandom(seed);
		errors = 0;
		checks = 0;
		n_redirect = 0;
		n_link = 0;
		n_stall = 0;
		rst = 1'b1;
		inst = '0;
		inst_valid = 1'b0;
		rs1_data = '0;
		rs2_data = '0;
		for (idx = 0; idx < mem_words; idx++)
			prog_mem[idx] = random_inst();
		m_pc = reset_pc;
		m_ex_valid = 1'b0;
		m_ex_inst = '0;
		m_ex_pc = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		#5;
		test_name = "reset";
		exp_redirect = 1'b0;
		exp_link = 1'b0;
		check_outputs();
		for (idx = 0; idx < n_inst + n_drain; idx++)
		begin
			@(negedge clk);
			drive_cycle(idx < n_inst);
			#5; // outputs settle well before the next rising edge.
			predict_outputs();
			check_outputs();
			advance_model();
		end
		$display("checks %0d, redirects %0d, links %0d, stalls %0d, errors %0d",
			checks, n_redirect, n_link, n_stall, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

endmodule
